// ==== rtl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and address width
`define CORE_XLEN 32

// Architectural registers x0..x31
`define CORE_NREGS 32

`define CORE_NOP   32'h0000_0013  // addi x0, x0, 0
`define CORE_ECALL 32'h0000_0073  // Ends the program once it retires

// First fetch address after rst
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== rtl/core_pkg.sv ====
`default_nettype none
`include "core_settings.svh"

package core_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Writeback source, resolved in MEM
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef struct packed {
    logic       rf_wen;     // Writes rd
    logic       mem_wen;    // SW
    wb_sel_e    wb_sel;
    alu_op_e    alu_op;
    logic       use_imm;    // Operand b from immediate
    logic       is_branch;
    logic       br_ne;      // BNE when set, BEQ otherwise
    logic       is_jal;
    logic       is_ecall;
    logic [4:0] rs1;        // Zero when not read
    logic [4:0] rs2;        // Zero when not read
    logic [4:0] rd;         // Zero when not written
  } ctrl_t;

  typedef struct packed {
    logic                  valid;
    ctrl_t                 ctrl;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] imm;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    ctrl_t                 ctrl;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] alu_out;     // Also the data address
    logic [`CORE_XLEN-1:0] store_data;  // Forwarded rs2
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    ctrl_t                 ctrl;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] result;  // Final writeback value
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/decoder.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "core_settings.svh"

module decoder (
  input  wire logic [`CORE_XLEN-1:0] inst,
  output core_pkg::ctrl_t            ctrl,
  output logic [`CORE_XLEN-1:0]      imm
);

  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_s;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_j;
  logic [2:0]            funct3;
  logic [6:0]            funct7;

  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Sign-extended immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl = '0;                     // Unknown encodings fall out as a NOP
    ctrl.wb_sel = core_pkg::WB_ALU;
    ctrl.alu_op = core_pkg::ALU_ADD;
    imm  = '0;
    case (core_pkg::opcode_e'(inst[6:0]))
      core_pkg::OPC_OP: begin
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.rd  = inst[11:7];
        ctrl.rf_wen = 1'b1;
        case (funct3)
          3'b000: begin
            if (funct7 == 7'b0100000) ctrl.alu_op = core_pkg::ALU_SUB;
            else if (funct7 != 7'b0000000) ctrl = '0;  // Not ADD or SUB
          end
          3'b100: ctrl.alu_op = core_pkg::ALU_XOR;
          3'b110: ctrl.alu_op = core_pkg::ALU_OR;
          3'b111: ctrl.alu_op = core_pkg::ALU_AND;
          default: ctrl = '0;  // Shifts and compares are not implemented
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin  // ADDI only
          ctrl.rs1     = inst[19:15];
          ctrl.rd      = inst[11:7];
          ctrl.rf_wen  = 1'b1;
          ctrl.use_imm = 1'b1;
          imm = imm_i;
        end
      end
      core_pkg::OPC_LOAD: begin
        if (funct3 == 3'b010) begin  // LW
          ctrl.rs1     = inst[19:15];
          ctrl.rd      = inst[11:7];
          ctrl.rf_wen  = 1'b1;
          ctrl.use_imm = 1'b1;
          ctrl.wb_sel  = core_pkg::WB_MEM;
          imm = imm_i;
        end
      end
      core_pkg::OPC_STORE: begin
        if (funct3 == 3'b010) begin  // SW
          ctrl.rs1     = inst[19:15];
          ctrl.rs2     = inst[24:20];
          ctrl.mem_wen = 1'b1;
          ctrl.use_imm = 1'b1;  // Address = rs1 + imm
          imm = imm_s;
        end
      end
      core_pkg::OPC_BRANCH: begin
        if (funct3[2:1] == 2'b00) begin  // BEQ, BNE
          ctrl.rs1       = inst[19:15];
          ctrl.rs2       = inst[24:20];
          ctrl.is_branch = 1'b1;
          ctrl.br_ne     = funct3[0];
          imm = imm_b;
        end
      end
      core_pkg::OPC_JAL: begin
        ctrl.rd     = inst[11:7];
        ctrl.rf_wen = 1'b1;
        ctrl.is_jal = 1'b1;
        ctrl.wb_sel = core_pkg::WB_PC4;  // Link value
        imm = imm_j;
      end
      core_pkg::OPC_SYSTEM: ctrl.is_ecall = (inst == `CORE_ECALL);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "core_settings.svh"

module reg_file (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [4:0]            rs1,
  input  wire logic [4:0]            rs2,
  output logic [`CORE_XLEN-1:0]      rs1_val,
  output logic [`CORE_XLEN-1:0]      rs2_val,
  input  wire logic                  wen,
  input  wire logic [4:0]            rd,
  input  wire logic [`CORE_XLEN-1:0] wdata
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
    end else if (wen && rd != 5'd0) begin  // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  // Write-through covers the WB to ID distance
  always_comb begin
    if (rs1 == 5'd0) rs1_val = '0;
    else if (wen && rd == rs1) rs1_val = wdata;
    else rs1_val = regs[rs1];
    if (rs2 == 5'd0) rs2_val = '0;
    else if (wen && rd == rs2) rs2_val = wdata;
    else rs2_val = regs[rs2];
  end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

// Select code 0 is the register file, 1 EX/MEM, 2 MEM/WB and 3 WB write-through
module hazard_unit (
  input  wire core_pkg::ctrl_t id_ctrl,
  input  wire core_pkg::ctrl_t ex_ctrl,
  input  wire core_pkg::ctrl_t mem_ctrl,
  input  wire core_pkg::ctrl_t wb_ctrl,
  input  wire logic            ex_valid,
  input  wire logic            mem_valid,
  input  wire logic            wb_valid,
  output logic [1:0]           fwd_a,
  output logic [1:0]           fwd_b,
  output logic                 stall
);

  // Producer writes a nonzero rd equal to rs
  function automatic logic writes(input core_pkg::ctrl_t c, input logic v,
                                  input logic [4:0] rs);
    return v && c.rf_wen && c.rd != 5'd0 && c.rd == rs;
  endfunction

  // Where the operand for rs comes from once ID moves to EX
  function automatic logic [1:0] pick(input logic [4:0] rs);
    if (writes(ex_ctrl, ex_valid, rs) && ex_ctrl.wb_sel != core_pkg::WB_MEM)
      return 2'd1;  // Load here is handled by the stall
    else if (writes(mem_ctrl, mem_valid, rs))
      return 2'd2;
    else if (writes(wb_ctrl, wb_valid, rs))
      return 2'd3;  // Already captured through write-through
    else
      return 2'd0;
  endfunction

  always_comb begin
    fwd_a = pick(id_ctrl.rs1);
    fwd_b = pick(id_ctrl.rs2);
  end

  // Load in EX feeding ID costs one bubble before the MEM/WB forward
  assign stall = ex_valid && ex_ctrl.rf_wen && ex_ctrl.wb_sel == core_pkg::WB_MEM &&
                 ex_ctrl.rd != 5'd0 &&
                 (ex_ctrl.rd == id_ctrl.rs1 || ex_ctrl.rd == id_ctrl.rs2);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "core_settings.svh"

module execute_stage (
  input  wire core_pkg::id_ex_t      id_ex,
  input  wire logic [1:0]            fwd_a,
  input  wire logic [1:0]            fwd_b,
  input  wire logic [`CORE_XLEN-1:0] mem_fwd,   // EX/MEM ALU result
  input  wire logic [`CORE_XLEN-1:0] wb_fwd,    // MEM/WB writeback value
  output core_pkg::ex_mem_t          ex_mem_next,
  output logic                       redirect,
  output logic [`CORE_XLEN-1:0]      target
);

  logic [`CORE_XLEN-1:0] rs1_fwd;
  logic [`CORE_XLEN-1:0] rs2_fwd;
  logic [`CORE_XLEN-1:0] op_b;
  logic [`CORE_XLEN-1:0] alu_out;
  logic                  taken;

  function automatic logic [`CORE_XLEN-1:0] fwd_mux(input logic [1:0] sel,
                                                    input logic [`CORE_XLEN-1:0] rf_val);
    case (sel)
      2'd1:    return mem_fwd;
      2'd2:    return wb_fwd;
      default: return rf_val;  // Register file or write-through
    endcase
  endfunction

  always_comb begin
    rs1_fwd = fwd_mux(fwd_a, id_ex.rs1_val);
    rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_val);
  end

  assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      core_pkg::ALU_SUB: alu_out = rs1_fwd - op_b;
      core_pkg::ALU_AND: alu_out = rs1_fwd & op_b;
      core_pkg::ALU_OR:  alu_out = rs1_fwd | op_b;
      core_pkg::ALU_XOR: alu_out = rs1_fwd ^ op_b;
      default:           alu_out = rs1_fwd + op_b;  // ADD, ADDI, LW/SW address
    endcase
  end

  // BEQ and BNE share one comparator
  assign taken    = id_ex.ctrl.is_branch && ((rs1_fwd == rs2_fwd) ^ id_ex.ctrl.br_ne);
  assign redirect = id_ex.valid && (id_ex.ctrl.is_jal || taken);
  assign target   = id_ex.pc + id_ex.imm;  // B or J immediate

  always_comb begin
    ex_mem_next.valid      = id_ex.valid;
    ex_mem_next.ctrl       = id_ex.ctrl;
    ex_mem_next.pc         = id_ex.pc;
    ex_mem_next.alu_out    = alu_out;
    ex_mem_next.store_data = rs2_fwd;  // SW data after forwarding
  end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "core_settings.svh"

module core_top (
  input  wire logic                  clk,
  input  wire logic                  rst,
  output logic [`CORE_XLEN-1:0]      imem_addr,
  input  wire logic [`CORE_XLEN-1:0] imem_inst,
  output logic [`CORE_XLEN-1:0]      dmem_addr,
  output logic [`CORE_XLEN-1:0]      dmem_wdata,
  output logic                       dmem_wen,
  input  wire logic [`CORE_XLEN-1:0] dmem_rdata,
  output logic                       exit
);

  logic [`CORE_XLEN-1:0] pc;
  logic                  if_id_valid;
  logic [`CORE_XLEN-1:0] if_id_pc;
  logic [`CORE_XLEN-1:0] if_id_inst;
  logic [`CORE_XLEN-1:0] id_inst;
  core_pkg::ctrl_t       id_ctrl;
  logic [`CORE_XLEN-1:0] id_imm;
  logic [`CORE_XLEN-1:0] rs1_val;
  logic [`CORE_XLEN-1:0] rs2_val;
  logic [1:0]            fwd_a;
  logic [1:0]            fwd_b;
  logic [1:0]            fwd_a_q;   // Travel with ID/EX
  logic [1:0]            fwd_b_q;
  logic                  stall;
  logic                  redirect;
  logic [`CORE_XLEN-1:0] target;
  logic                  wb_wen;
  core_pkg::id_ex_t      id_ex_next;
  core_pkg::id_ex_t      id_ex;
  core_pkg::ex_mem_t     ex_mem_next;
  core_pkg::ex_mem_t     ex_mem;
  core_pkg::mem_wb_t     mem_wb_next;
  core_pkg::mem_wb_t     mem_wb;

  assign imem_addr = pc;

  // Redirect wins, stall freezes fetch
  always_ff @(posedge clk) begin
    if (rst) pc <= `CORE_RESET_PC;
    else if (redirect) pc <= target;
    else if (!stall) pc <= pc + `CORE_XLEN'd4;
  end

  always_ff @(posedge clk) begin
    if (rst) if_id_valid <= 1'b0;
    else if (redirect) if_id_valid <= 1'b0;  // Wrong-path fetch
    else if (!stall) if_id_valid <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_pc   <= pc;
      if_id_inst <= imem_inst;
    end
  end

  // Empty slot decodes as NOP so it never stalls or forwards
  assign id_inst = if_id_valid ? if_id_inst : `CORE_NOP;

  decoder u_decoder (
    .inst (id_inst),
    .ctrl (id_ctrl),
    .imm  (id_imm)
  );

  assign wb_wen = mem_wb.valid && mem_wb.ctrl.rf_wen;

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs1     (id_ctrl.rs1),
    .rs2     (id_ctrl.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wen     (wb_wen),
    .rd      (mem_wb.ctrl.rd),
    .wdata   (mem_wb.result)
  );

  hazard_unit u_hazard_unit (
    .id_ctrl   (id_ctrl),
    .ex_ctrl   (id_ex.ctrl),
    .mem_ctrl  (ex_mem.ctrl),
    .wb_ctrl   (mem_wb.ctrl),
    .ex_valid  (id_ex.valid),
    .mem_valid (ex_mem.valid),
    .wb_valid  (mem_wb.valid),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b),
    .stall     (stall)
  );

  always_comb begin
    id_ex_next.valid   = if_id_valid && !stall && !redirect;  // Bubble on stall or flush
    id_ex_next.ctrl    = id_ctrl;
    id_ex_next.pc      = if_id_pc;
    id_ex_next.rs1_val = rs1_val;
    id_ex_next.rs2_val = rs2_val;
    id_ex_next.imm     = id_imm;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex   <= id_ex_next;
      fwd_a_q <= fwd_a;
      fwd_b_q <= fwd_b;
    end
  end

  execute_stage u_execute_stage (
    .id_ex       (id_ex),
    .fwd_a       (fwd_a_q),
    .fwd_b       (fwd_b_q),
    .mem_fwd     (ex_mem.alu_out),
    .wb_fwd      (mem_wb.result),
    .ex_mem_next (ex_mem_next),
    .redirect    (redirect),
    .target      (target)
  );

  always_ff @(posedge clk) begin
    if (rst) ex_mem.valid <= 1'b0;
    else ex_mem <= ex_mem_next;
  end

  // Single-cycle data port straight off EX/MEM
  assign dmem_addr  = ex_mem.alu_out;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_wen   = ex_mem.valid && ex_mem.ctrl.mem_wen;

  always_comb begin
    mem_wb_next.valid = ex_mem.valid;
    mem_wb_next.ctrl  = ex_mem.ctrl;
    mem_wb_next.pc    = ex_mem.pc;
    case (ex_mem.ctrl.wb_sel)
      core_pkg::WB_MEM: mem_wb_next.result = dmem_rdata;
      core_pkg::WB_PC4: mem_wb_next.result = ex_mem.pc + `CORE_XLEN'd4;  // JAL link
      default:          mem_wb_next.result = ex_mem.alu_out;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) mem_wb.valid <= 1'b0;
    else mem_wb <= mem_wb_next;
  end

  // Sticky until rst
  always_ff @(posedge clk) begin
    if (rst) exit <= 1'b0;
    else if (mem_wb.valid && mem_wb.ctrl.is_ecall) exit <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
  parameter int period_ns = 8
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(period_ns / 2) clk = ~clk;  // 50% duty

endmodule

`default_nettype wire

// ==== tests/core_asserts.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "core_settings.svh"

module core_asserts (
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic                  exit,
  input wire logic                  dmem_wen,
  input wire logic [`CORE_XLEN-1:0] dmem_addr
);

  int fail_count = 0;  // Read by the testbench at the end of the run

  // Exit is sticky until rst
  exit_sticky: assert property (@(posedge clk) (exit && !rst) |=> exit)
    else begin
      fail_count++;
      $error("exit fell while rst was low");
    end

  // SW only, so every data write is a full word
  store_aligned: assert property (@(posedge clk) disable iff (rst)
                                  dmem_wen |-> dmem_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("data write to unaligned address %h", dmem_addr);
    end

  // One edge for the EX/MEM valid bit to clear
  quiet_in_reset: assert property (@(posedge clk) (rst ##1 rst) |-> !dmem_wen)
    else begin
      fail_count++;
      $error("data write while rst was high");
    end

endmodule

`default_nettype wire

// ==== tests/core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "core_settings.svh"

module core_tb;

  localparam int max_cycles = 5 * 200;  // 200 cycles for each of the five tests

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_inst;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_wen;
  logic [31:0] dmem_rdata;
  logic        exit;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog_mem [256];  // Staged program that is copied in while rst is high
  logic [31:0] dm_init [256];   // Staged data image
  int          prog_len;
  int          cycle_count = 0;
  int          late_writes;      // Data writes seen once exit is high
  int          checks;
  int          errors;
  int          test_errors;
  int          tests_run;

  tb_clock #(.period_ns(8)) u_clock (.clk(clk));

  core_top dut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_inst  (imem_inst),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wen   (dmem_wen),
    .dmem_rdata (dmem_rdata),
    .exit       (exit)
  );

  bind core_top core_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .exit      (exit),
    .dmem_wen  (dmem_wen),
    .dmem_addr (dmem_addr)
  );

  // Single-cycle memories that stay quiet while the core is in reset
  assign imem_inst  = rst ? `CORE_NOP : imem[imem_addr[9:2]];
  assign dmem_rdata = rst ? 32'h0 : dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        imem[i] <= prog_mem[i];
        dmem[i] <= dm_init[i];
      end
    end else if (dmem_wen) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;  // Write lands at the edge
    end
  end

  always @(posedge clk) begin
    if (rst) late_writes <= 0;
    else if (exit && dmem_wen) late_writes <= late_writes + 1;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // RV32I encoders
  function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] add_imm(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // f3 of 0 selects BEQ and 1 selects BNE
  function automatic logic [31:0] cond_branch(input int f3, input int rs1, input int rs2,
                                              input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jump_link(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // Untouched data words differ for every word index
  function automatic logic [31:0] fill_word(input int idx);
    return {16'hd47a, idx[7:0], ~idx[7:0]};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mem(input string what, input int addr, input logic [31:0] exp);
    check($sformatf("%s at %h", what, addr[11:0]), dmem[addr[9:2]], exp);
  endtask

  task automatic start_program();
    for (int i = 0; i < 256; i++) begin
      prog_mem[i] = `CORE_NOP;
      dm_init[i]  = fill_word(i);
    end
    prog_len    = 0;
    test_errors = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    prog_mem[prog_len] = word;
    prog_len++;
  endtask

  // Reset, run to ECALL, then watch for stray stores
  task automatic run_program();
    emit(`CORE_ECALL);
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("exit after reset", {31'b0, exit}, 32'd0);
    while (exit !== 1'b1) @(negedge clk);  // Bounded by the cycle counter
    repeat (8) @(negedge clk);
    check("exit held after ECALL", {31'b0, exit}, 32'd1);
    check("data writes after ECALL", late_writes, 32'd0);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("%-16s %s, %0d mismatches", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
  endtask

  task automatic alu_chain_test();
    logic [31:0] e [1:8];
    start_program();
    emit(add_imm(1, 0, 100));
    emit(add_imm(2, 1, 23));        // EX/MEM forward
    emit(reg_op(0, 0, 3, 1, 2));    // add forwarded from both stages
    emit(reg_op('h20, 0, 4, 3, 1)); // sub
    emit(reg_op(0, 7, 5, 4, 3));    // and
    emit(reg_op(0, 6, 6, 5, 2));    // or
    emit(reg_op(0, 4, 7, 6, 4));    // xor
    emit(add_imm(8, 0, -5));        // Negative immediate
    for (int r = 8; r >= 1; r--) emit(store_word(r, 0, 'h200 + 4 * (r - 1)));
    run_program();
    e[1] = 32'd100;
    e[2] = e[1] + 32'd23;
    e[3] = e[1] + e[2];
    e[4] = e[3] - e[1];
    e[5] = e[4] & e[3];
    e[6] = e[5] | e[2];
    e[7] = e[6] ^ e[4];
    e[8] = 32'd0 - 32'd5;
    for (int r = 1; r <= 8; r++) check_mem($sformatf("x%0d", r), 'h200 + 4 * (r - 1), e[r]);
    finish_test("alu_chain");
  endtask

  task automatic load_use_test();
    start_program();
    emit(add_imm(1, 0, 'h5a5));
    emit(store_word(1, 0, 'h100));
    emit(load_word(2, 0, 'h100));
    emit(reg_op(0, 0, 3, 2, 1));    // Uses the load at once
    emit(store_word(3, 0, 'h104));
    emit(load_word(4, 0, 'h100));
    emit(store_word(4, 0, 'h108));  // Load data as store data
    run_program();
    check_mem("stored constant", 'h100, 32'h5a5);
    check_mem("load-use sum", 'h104, 32'h5a5 + 32'h5a5);
    check_mem("load to store", 'h108, 32'h5a5);
    finish_test("load_use");
  endtask

  task automatic branch_test();
    start_program();
    emit(add_imm(1, 0, 7));
    emit(add_imm(2, 0, 7));
    emit(add_imm(3, 0, 9));
    emit(add_imm(9, 0, 'h55));      // Marker
    emit(cond_branch(0, 1, 2, 12)); // beq taken
    emit(store_word(9, 0, 'h100));  // Shadow
    emit(store_word(9, 0, 'h104));  // Shadow
    emit(cond_branch(1, 1, 2, 8));  // bne not taken
    emit(store_word(9, 0, 'h108));
    emit(cond_branch(0, 1, 3, 8));  // beq not taken
    emit(store_word(9, 0, 'h10c));
    emit(cond_branch(1, 1, 3, 12)); // bne taken
    emit(store_word(9, 0, 'h110));
    emit(store_word(9, 0, 'h114));
    emit(store_word(9, 0, 'h118));  // Branch target
    run_program();
    check_mem("beq shadow", 'h100, fill_word(64));
    check_mem("beq shadow", 'h104, fill_word(65));
    check_mem("bne fall-through", 'h108, 32'h55);
    check_mem("beq fall-through", 'h10c, 32'h55);
    check_mem("bne shadow", 'h110, fill_word(68));
    check_mem("bne shadow", 'h114, fill_word(69));
    check_mem("bne target", 'h118, 32'h55);
    finish_test("branches");
  endtask

  task automatic jal_test();
    int jal_a;
    int jal_b;
    start_program();
    emit(add_imm(1, 0, 'h77));
    jal_a = prog_len * 4;
    emit(jump_link(5, 12));
    emit(store_word(1, 0, 'h100));  // Skipped
    emit(store_word(1, 0, 'h104));  // Skipped
    emit(store_word(5, 0, 'h108));  // Link value
    jal_b = prog_len * 4;
    emit(jump_link(6, 8));
    emit(store_word(1, 0, 'h10c));  // Skipped
    emit(store_word(6, 0, 'h110));
    run_program();
    check_mem("jal skip", 'h100, fill_word(64));
    check_mem("jal skip", 'h104, fill_word(65));
    check_mem("first link", 'h108, jal_a + 4);
    check_mem("jal skip", 'h10c, fill_word(67));
    check_mem("second link", 'h110, jal_b + 4);
    finish_test("jal");
  endtask

  task automatic random_operand_test();
    logic [31:0] a [3];
    logic [31:0] b [3];
    start_program();
    for (int k = 0; k < 3; k++) begin
      a[k] = $urandom;
      b[k] = $urandom;
      dm_init[64 + 2 * k] = a[k];
      dm_init[65 + 2 * k] = b[k];
      emit(load_word(1, 0, 'h100 + 8 * k));
      emit(load_word(2, 0, 'h104 + 8 * k));
      emit(reg_op(0, 0, 3, 1, 2));    // add stalls on x2
      emit(reg_op('h20, 0, 4, 1, 2)); // sub
      emit(reg_op(0, 4, 5, 1, 2));    // xor
      emit(store_word(3, 0, 'h200 + 12 * k));
      emit(store_word(4, 0, 'h204 + 12 * k));
      emit(store_word(5, 0, 'h208 + 12 * k));
    end
    run_program();
    for (int k = 0; k < 3; k++) begin
      check_mem("random add", 'h200 + 12 * k, a[k] + b[k]);
      check_mem("random sub", 'h204 + 12 * k, a[k] - b[k]);
      check_mem("random xor", 'h208 + 12 * k, a[k] ^ b[k]);
    end
    finish_test("random_ops");
  endtask

  initial begin
    rst       = 1'b1;
    void'($urandom(45));  // One seed for the whole run
    checks    = 0;
    errors    = 0;
    tests_run = 0;
    alu_chain_test();
    load_use_test();
    branch_test();
    jal_test();
    random_operand_test();
    check("assertion failures", dut.u_asserts.fail_count, 32'd0);
    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/core_top.sv
tests/tb_clock.sv
tests/core_asserts.sv
tests/core_tb.sv
